// File: src/fpu_wrap_pkg.sv
package fpu_wrap_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int unsigned FLEN          = 32;  // FP32 operands and result
    localparam int unsigned MAN_BITS      = 23;  // Mantissa field, exponent sits above it
    localparam int unsigned TRANS_ID_BITS = 3;   // Issue tag
    localparam int unsigned STATUS_BITS   = 5;   // NV DZ OF UF NX, top bit first
    localparam int unsigned CLASS_BITS    = 10;  // RISC-V fclass mask

    // Only the invalid flag can ever be raised by this unit
    localparam int unsigned STATUS_NV     = 4;

    // Canonical quiet NaN returned by min/max when both inputs are NaN
    localparam logic [FLEN-1:0] CANON_NAN = 32'h7FC0_0000;

    // --------------------
    // Types
    // --------------------
    typedef logic [2:0]               rm_t;        // Rounding field, reused as op select
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [STATUS_BITS-1:0]   status_t;

    // Core side operator
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,   // FP reg to int reg
        FMV_X2F  = 3'd5    // Int reg to FP reg
    } fu_op_e;

    // Unit side operation
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // --------------------
    // Mode encodings
    // --------------------
    // Sign injection
    localparam rm_t RM_SGNJ  = 3'b000;   // Take sign of b
    localparam rm_t RM_SGNJN = 3'b001;   // Inverted sign of b
    localparam rm_t RM_SGNJX = 3'b010;   // Xor of both signs
    localparam rm_t RM_PASS  = 3'b011;   // Pass a untouched, used for moves

    // Min/max
    localparam rm_t RM_MIN   = 3'b000;
    localparam rm_t RM_MAX   = 3'b001;

    // Compare
    localparam rm_t RM_LE    = 3'b000;
    localparam rm_t RM_LT    = 3'b001;
    localparam rm_t RM_EQ    = 3'b010;

endpackage

// File: src/fpu_op_decoder.sv
`timescale 1ns/1ps

module fpu_op_decoder import fpu_wrap_pkg::*; (
    input  fu_op_e   operator_i,   // Core operator
    input  rm_t      rm_i,         // Core rounding field, carries the op select
    output unit_op_e unit_op_o,    // Operation for the unit
    output logic     op_mod_o,     // Operation modifier
    output rm_t      mode_o        // Operation select inside the unit
);

    // --------------------
    // Operator translation
    // --------------------
    // Purely combinational, the hold buffer sits right behind this block

    always_comb begin : op_translate
        // Defaults, scalar ops keep the low two rm bits
        unit_op_o = SGNJ;
        op_mod_o  = 1'b0;
        mode_o    = {1'b0, rm_i[1:0]};   // Top bit is an alternate format flag upstream

        unique case (operator_i)
            // Sign injection, mode picks plain / negated / xored
            FSGNJ: begin
                unit_op_o = SGNJ;
            end

            // Min or max selected by rm bit 0
            FMIN_MAX: begin
                unit_op_o = MINMAX;
            end

            // le / lt / eq
            FCMP: begin
                unit_op_o = CMP;
            end

            // Classify ignores the mode entirely
            FCLASS: begin
                unit_op_o = CLASSIFY;
            end

            // Move to integer side
            FMV_F2X: begin
                unit_op_o = SGNJ;      // Reuse sign injection datapath
                mode_o    = RM_PASS;   // No sign change
                op_mod_o  = 1'b1;      // Marks integer destination
            end

            // Move to FP side
            FMV_X2F: begin
                unit_op_o = SGNJ;
                mode_o    = RM_PASS;
            end

            // Unused operator codes degrade to a harmless passthrough
            default: begin
                unit_op_o = SGNJ;
                mode_o    = RM_PASS;
            end
        endcase
    end

endmodule

// File: src/fpu_hold_buffer.sv
`timescale 1ns/1ps

module fpu_hold_buffer import fpu_wrap_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    // Issue side
    input  logic            fpu_valid_i,
    output logic            fpu_ready_o,
    input  unit_op_e        unit_op_i,
    input  logic            op_mod_i,
    input  rm_t             mode_i,
    input  logic [FLEN-1:0] operand_a_i,
    input  logic [FLEN-1:0] operand_b_i,
    input  trans_id_t       trans_id_i,
    // Unit side
    output logic            unit_valid_o,
    input  logic            unit_ready_i,
    output unit_op_e        unit_op_o,
    output logic            op_mod_o,
    output rm_t             mode_o,
    output logic [FLEN-1:0] operand_a_o,
    output logic [FLEN-1:0] operand_b_o,
    output trans_id_t       trans_id_o
);

    typedef enum logic {READY, STALL} state_e;

    state_e          state_q, state_d;
    logic            hold_inputs;   // Capture the refused op
    logic            use_hold;      // Present held op to the unit
    unit_op_e        op_q;
    logic            mod_q;
    rm_t             mode_q;
    logic [FLEN-1:0] a_q, b_q;
    trans_id_t       tag_q;

    // --------------------
    // Protocol inversion
    // --------------------
    always_comb begin : inv_fsm
        fpu_ready_o  = 1'b0;
        unit_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            READY: begin
                fpu_ready_o  = 1'b1;          // Look ready to issue
                unit_valid_o = fpu_valid_i;   // Straight through
                if (fpu_valid_i && !unit_ready_i) begin
                    fpu_ready_o = 1'b0;       // Withdraw the token
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;          // Held op always pending
                use_hold     = 1'b1;
                if (unit_ready_i) begin
                    fpu_ready_o = 1'b1;       // Issue sees its transfer now
                    state_d     = READY;
                end
            end
            default: ;
        endcase

        if (flush_i) state_d = READY;         // Drop any parked op
    end

    always_ff @(posedge clk_i) begin : state_reg
        if (rst_i) state_q <= READY;
        else       state_q <= state_d;
    end

    // Hold register, payload only
    always_ff @(posedge clk_i) begin : hold_reg
        if (hold_inputs) begin
            op_q   <= unit_op_i;
            mod_q  <= op_mod_i;
            mode_q <= mode_i;
            a_q    <= operand_a_i;
            b_q    <= operand_b_i;
            tag_q  <= trans_id_i;
        end
    end

    assign unit_op_o   = use_hold ? op_q   : unit_op_i;
    assign op_mod_o    = use_hold ? mod_q  : op_mod_i;
    assign mode_o      = use_hold ? mode_q : mode_i;
    assign operand_a_o = use_hold ? a_q    : operand_a_i;
    assign operand_b_o = use_hold ? b_q    : operand_b_i;
    assign trans_id_o  = use_hold ? tag_q  : trans_id_i;

endmodule

// File: src/fp32_noncomp_unit.sv
`timescale 1ns/1ps

module fp32_noncomp_unit import fpu_wrap_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  unit_op_e        unit_op_i,
    input  logic            op_mod_i,     // Integer destination for moves
    input  rm_t             mode_i,
    input  logic [FLEN-1:0] operand_a_i,
    input  logic [FLEN-1:0] operand_b_i,
    input  trans_id_t       tag_i,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output logic [FLEN-1:0] result_o,
    output status_t         status_o,
    output trans_id_t       tag_o
);

    // Per operand class bits
    typedef struct packed {
        logic sign;
        logic zero;
        logic sub;
        logic inf;
        logic qnan;
        logic snan;
    } fp_info_t;

    function automatic fp_info_t fp_info(input logic [FLEN-1:0] x);
        fp_info_t info;
        logic     exp_ones;
        logic     exp_zero;
        logic     man_zero;
        exp_ones  = &x[FLEN-2:MAN_BITS];
        exp_zero  = ~|x[FLEN-2:MAN_BITS];
        man_zero  = ~|x[MAN_BITS-1:0];
        info.sign = x[FLEN-1];
        info.zero = exp_zero & man_zero;
        info.sub  = exp_zero & ~man_zero;
        info.inf  = exp_ones & man_zero;
        info.qnan = exp_ones & x[MAN_BITS-1];                // Quiet bit set
        info.snan = exp_ones & ~man_zero & ~x[MAN_BITS-1];
        return info;
    endfunction

    logic            adv;                   // Whole pipe moves
    logic            s1_valid_q, s2_valid_q;
    unit_op_e        s1_op_q;
    rm_t             s1_mode_q;
    logic [FLEN-1:0] s1_a_q, s1_b_q;
    trans_id_t       s1_tag_q;
    fp_info_t        s1_ia_q, s1_ib_q;      // Classes of a and b
    logic [FLEN-1:0] s2_res_q;
    status_t         s2_status_q;
    trans_id_t       s2_tag_q;

    logic            a_nan, b_nan, any_snan, both_zero;
    logic            a_lt_b;                // Total order, -0 below +0
    logic            a_normal;
    logic [CLASS_BITS-1:0] class_mask;
    logic [FLEN-1:0] res_d;
    logic            nv_d;
    status_t         status_d;

    assign adv        = ~s2_valid_q | out_ready_i;
    assign in_ready_o = adv;

    // --------------------
    // Pipeline registers
    // --------------------
    always_ff @(posedge clk_i) begin : valid_regs
        if (rst_i || flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (adv) begin
            s1_valid_q <= in_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        if (adv && in_valid_i) begin            // Stage 1 registers and classifies
            s1_op_q   <= unit_op_i;
            s1_mode_q <= mode_i;
            s1_a_q    <= operand_a_i;
            s1_b_q    <= operand_b_i;
            s1_tag_q  <= tag_i;
            s1_ia_q   <= fp_info(operand_a_i);
            s1_ib_q   <= fp_info(operand_b_i);
        end
        if (adv && s1_valid_q) begin            // Stage 2 result
            s2_res_q    <= res_d;
            s2_status_q <= status_d;
            s2_tag_q    <= s1_tag_q;
        end
    end

    // --------------------
    // Stage 2 datapath
    // --------------------
    assign a_nan     = s1_ia_q.qnan | s1_ia_q.snan;
    assign b_nan     = s1_ib_q.qnan | s1_ib_q.snan;
    assign any_snan  = s1_ia_q.snan | s1_ib_q.snan;
    assign both_zero = s1_ia_q.zero & s1_ib_q.zero;   // +0 == -0 for compare
    assign a_lt_b    = (s1_ia_q.sign != s1_ib_q.sign) ? s1_ia_q.sign :
                       s1_ia_q.sign ? (s1_a_q[FLEN-2:0] > s1_b_q[FLEN-2:0]) :
                                      (s1_a_q[FLEN-2:0] < s1_b_q[FLEN-2:0]);
    assign a_normal  = ~(s1_ia_q.zero | s1_ia_q.sub | s1_ia_q.inf | a_nan);

    // RISC-V fclass layout, NaN bits ignore the sign
    assign class_mask = {s1_ia_q.qnan, s1_ia_q.snan,
                         ~s1_ia_q.sign & s1_ia_q.inf,  ~s1_ia_q.sign & a_normal,
                         ~s1_ia_q.sign & s1_ia_q.sub,  ~s1_ia_q.sign & s1_ia_q.zero,
                         s1_ia_q.sign & s1_ia_q.zero,  s1_ia_q.sign & s1_ia_q.sub,
                         s1_ia_q.sign & a_normal,      s1_ia_q.sign & s1_ia_q.inf};

    always_comb begin : compute
        res_d = s1_a_q;
        nv_d  = 1'b0;
        unique case (s1_op_q)
            SGNJ: begin
                unique case (s1_mode_q)
                    RM_SGNJ:  res_d = {s1_ib_q.sign, s1_a_q[FLEN-2:0]};
                    RM_SGNJN: res_d = {~s1_ib_q.sign, s1_a_q[FLEN-2:0]};
                    RM_SGNJX: res_d = {s1_ia_q.sign ^ s1_ib_q.sign, s1_a_q[FLEN-2:0]};
                    // Moves, int side extension is a no-op at FP32 width
                    default:  res_d = s1_a_q;
                endcase
            end
            MINMAX: begin
                nv_d = any_snan;
                if (a_nan && b_nan)          res_d = CANON_NAN;
                else if (a_nan)              res_d = s1_b_q;   // Other operand wins
                else if (b_nan)              res_d = s1_a_q;
                else if (s1_mode_q == RM_MIN) res_d = a_lt_b ? s1_a_q : s1_b_q;
                else                         res_d = a_lt_b ? s1_b_q : s1_a_q;
            end
            CMP: begin
                res_d = '0;
                unique case (s1_mode_q)
                    RM_LE: begin
                        nv_d     = a_nan | b_nan;            // Signaling compare
                        res_d[0] = ~(a_nan | b_nan) & ((a_lt_b & ~both_zero) |
                                   both_zero | (s1_a_q == s1_b_q));
                    end
                    RM_LT: begin
                        nv_d     = a_nan | b_nan;
                        res_d[0] = ~(a_nan | b_nan) & a_lt_b & ~both_zero;
                    end
                    RM_EQ: begin
                        nv_d     = any_snan;                 // Quiet compare
                        res_d[0] = ~(a_nan | b_nan) & (both_zero | (s1_a_q == s1_b_q));
                    end
                    default: ;                               // Result stays 0
                endcase
            end
            CLASSIFY: res_d = {{(FLEN-CLASS_BITS){1'b0}}, class_mask};
            default: ;
        endcase
    end

    always_comb begin : flags
        status_d            = '0;
        status_d[STATUS_NV] = nv_d;   // No other flag can occur here
    end

    assign out_valid_o = s2_valid_q;
    assign result_o    = s2_res_q;
    assign status_o    = s2_status_q;
    assign tag_o       = s2_tag_q;

endmodule

// File: src/fpu_wrap_top.sv
`timescale 1ns/1ps

module fpu_wrap_top import fpu_wrap_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    // Issue handshake
    input  logic            fpu_valid_i,
    output logic            fpu_ready_o,
    input  fu_op_e          operator_i,
    input  rm_t             rm_i,
    input  logic [FLEN-1:0] operand_a_i,
    input  logic [FLEN-1:0] operand_b_i,
    input  trans_id_t       trans_id_i,
    // Writeback handshake
    output logic            result_valid_o,
    input  logic            result_ready_i,
    output logic [FLEN-1:0] result_o,
    output status_t         status_o,
    output trans_id_t       trans_id_o
);

    // Decoder to buffer
    unit_op_e        dec_op;
    logic            dec_mod;
    rm_t             dec_mode;

    // Buffer to unit
    logic            unit_valid, unit_ready;
    unit_op_e        unit_op;
    logic            unit_mod;
    rm_t             unit_mode;
    logic [FLEN-1:0] unit_a, unit_b;
    trans_id_t       unit_tag;

    // --------------------
    // Chain of blocks
    // --------------------
    fpu_op_decoder i_op_decoder (
        .operator_i (operator_i),
        .rm_i       (rm_i),
        .unit_op_o  (dec_op),
        .op_mod_o   (dec_mod),
        .mode_o     (dec_mode)
    );

    fpu_hold_buffer i_hold_buffer (
        .clk_i, .rst_i, .flush_i,
        .fpu_valid_i  (fpu_valid_i),
        .fpu_ready_o  (fpu_ready_o),
        .unit_op_i    (dec_op),
        .op_mod_i     (dec_mod),
        .mode_i       (dec_mode),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .trans_id_i   (trans_id_i),
        .unit_valid_o (unit_valid),
        .unit_ready_i (unit_ready),
        .unit_op_o    (unit_op),
        .op_mod_o     (unit_mod),
        .mode_o       (unit_mode),
        .operand_a_o  (unit_a),
        .operand_b_o  (unit_b),
        .trans_id_o   (unit_tag)
    );

    fp32_noncomp_unit i_noncomp (
        .clk_i, .rst_i, .flush_i,
        .in_valid_i  (unit_valid),
        .in_ready_o  (unit_ready),
        .unit_op_i   (unit_op),
        .op_mod_i    (unit_mod),
        .mode_i      (unit_mode),
        .operand_a_i (unit_a),
        .operand_b_i (unit_b),
        .tag_i       (unit_tag),
        .out_valid_o (result_valid_o),
        .out_ready_i (result_ready_i),
        .result_o    (result_o),
        .status_o    (status_o),
        .tag_o       (trans_id_o)
    );

endmodule

// File: sim/fpu_wrap_properties.sv
`timescale 1ns/1ps

module fpu_wrap_properties import fpu_wrap_pkg::*; (
    input logic            clk_i,
    input logic            rst_i,
    input logic            flush_i,
    input logic            fpu_valid_i,
    input logic            fpu_ready_o,
    input fu_op_e          operator_i,
    input rm_t             rm_i,
    input logic [FLEN-1:0] operand_a_i,
    input logic [FLEN-1:0] operand_b_i,
    input trans_id_t       trans_id_i,
    input logic            result_valid_o,
    input logic            result_ready_i,
    input logic [FLEN-1:0] result_o,
    input status_t         status_o,
    input trans_id_t       trans_id_o,
    input logic            s2_load_i,   // Stage 1 op moves into stage 2
    input unit_op_e        s1_op_i      // Op sitting in stage 1
);

    // --------------------
    // Handshake rules
    // --------------------
    // Refused issue keeps its op on the bus
    assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        fpu_valid_i && !fpu_ready_o |=> fpu_valid_i &&
            $stable({operator_i, rm_i, operand_a_i, operand_b_i, trans_id_i}))
        else $error("Issue side changed its operation while refused");

    // Stalled writeback holds still
    assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        result_valid_o && !result_ready_i |=> result_valid_o &&
            $stable({result_o, status_o, trans_id_o}))
        else $error("Result changed while stalled");

    // --------------------
    // Flag rules
    // --------------------
    assert property (@(posedge clk_i) disable iff (rst_i)
        s2_load_i && (s1_op_i inside {SGNJ, CLASSIFY}) |=> !status_o[STATUS_NV])
        else $error("Invalid flag raised by sign injection or classify");

endmodule

// File: sim/fpu_wrap_tb.sv
`timescale 1ns/1ps

module fpu_wrap_tb import fpu_wrap_pkg::*; ();

    typedef struct packed {
        logic [FLEN-1:0] res;
        status_t         st;
        trans_id_t       tag;
        int              cyc;   // Cycle of acceptance
    } exp_t;

    logic            clk_i, rst_i, flush_i;
    logic            fpu_valid_i, fpu_ready_o, result_valid_o, result_ready_i;
    fu_op_e          operator_i;
    rm_t             rm_i;
    logic [FLEN-1:0] operand_a_i, operand_b_i, result_o;
    trans_id_t       trans_id_i, trans_id_o, next_tag;
    status_t         status_o;

    exp_t        exp_q[$];          // Accepted, not yet returned
    logic [31:0] lfsr = 32'h4958;
    int          cycle, issued, stalls, errors, tests;
    logic        lat_check, timed_out;

    fpu_wrap_top dut_i (.*);

    bind fpu_wrap_top fpu_wrap_properties props_i (
        .*,
        .s2_load_i (i_noncomp.adv & i_noncomp.s1_valid_q),
        .s1_op_i   (i_noncomp.s1_op_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;   // Galois step
        end
        return v;
    endfunction

    // Leans toward the special encodings
    function automatic logic [FLEN-1:0] pick_operand();
        logic       s;
        logic [2:0] kind;
        s    = 1'(rand_bits(1));
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0: return {s, 31'h0};                               // Signed zero
            3'd1: return {s, 31'h7F80_0000};                       // Infinity
            3'd2: return {s, 9'h1FF, 22'(rand_bits(22))};          // Quiet NaN
            3'd3: return {s, 9'h1FE, 22'(rand_bits(22)) | 22'h1};  // Signaling NaN
            3'd4: return {s, 8'h00, 23'(rand_bits(23)) | 23'h1};   // Subnormal
            default: return rand_bits(32);
        endcase
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic logic nan_of(input logic [FLEN-1:0] x);
        return &x[30:23] && |x[22:0];
    endfunction

    function automatic logic snan_of(input logic [FLEN-1:0] x);
        return nan_of(x) && !x[22];
    endfunction

    // Unsigned key in numeric order, -0 just below +0
    function automatic logic [31:0] order_key(input logic [FLEN-1:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [FLEN-1:0] class_of(input logic [FLEN-1:0] x);
        int idx;
        if (nan_of(x))               idx = x[22] ? 9 : 8;
        else if (&x[30:23])          idx = x[31] ? 0 : 7;
        else if (x[30:0] == 31'h0)   idx = x[31] ? 3 : 4;
        else if (x[30:23] == 8'h0)   idx = x[31] ? 2 : 5;
        else                         idx = x[31] ? 1 : 6;
        return 32'd1 << idx;
    endfunction

    function automatic exp_t model(input fu_op_e op, input rm_t rm,
                                   input logic [FLEN-1:0] a, input logic [FLEN-1:0] b);
        exp_t       e;
        logic [2:0] m;
        logic       any_nan, eq, lt;
        e       = '0;
        m       = (op == FMV_F2X || op == FMV_X2F) ? 3'b011 : {1'b0, rm[1:0]};
        any_nan = nan_of(a) || nan_of(b);
        eq      = !any_nan && (a == b || (a[30:0] == 31'h0 && b[30:0] == 31'h0));
        lt      = !any_nan && !eq && order_key(a) < order_key(b);
        case (op)
            FCMP: begin
                e.res[0]        = (m == 3'd0) ? (lt || eq) : (m == 3'd1) ? lt : eq;
                e.st[STATUS_NV] = (m == 3'd2) ? (snan_of(a) || snan_of(b)) : any_nan;
            end
            FMIN_MAX: begin
                e.st[STATUS_NV] = snan_of(a) || snan_of(b);
                if (nan_of(a) && nan_of(b)) e.res = CANON_NAN;
                else if (nan_of(a))         e.res = b;
                else if (nan_of(b))         e.res = a;
                else e.res = ((order_key(a) < order_key(b)) == (m == 3'd0)) ? a : b;
            end
            FCLASS: e.res = class_of(a);
            default: begin                                   // Sign injection and moves
                case (m)
                    3'd0:    e.res = {b[31], a[30:0]};
                    3'd1:    e.res = {~b[31], a[30:0]};
                    3'd2:    e.res = {a[31] ^ b[31], a[30:0]};
                    default: e.res = a;
                endcase
            end
        endcase
        return e;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_result(input logic [FLEN-1:0] got, input logic [FLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: result %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: status %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input trans_id_t got, input trans_id_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: tag %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0d ns: latency %0d cycles, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // One clock of traffic
    // --------------------
    // Handshakes are read at the falling edge, inputs change 5 ns after the rising one
    task automatic step(input int vprob, input int rprob, input logic [5:0] mask);
        exp_t       e;
        logic       took;
        logic [2:0] op;
        @(negedge clk_i);
        took = fpu_valid_i && fpu_ready_o;
        if (took) begin
            e     = model(operator_i, rm_i, operand_a_i, operand_b_i);
            e.tag = trans_id_i;
            e.cyc = cycle;
            exp_q.push_back(e);
            issued++;
        end
        if (fpu_valid_i && !fpu_ready_o) stalls++;      // Buffer is parking an op
        if (result_valid_o && result_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Result with tag %0d arrived with nothing outstanding", trans_id_o);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_result(result_o, e.res);
                check_status(status_o, e.st);
                check_tag(trans_id_o, e.tag);
                if (lat_check) check_latency(cycle - e.cyc, 2);
            end
        end
        @(posedge clk_i);
        cycle++;
        #5;
        result_ready_i = rand_bits(2) < rprob;
        if (!fpu_valid_i || took) begin                 // Refused op stays put
            fpu_valid_i = rand_bits(2) < vprob;
            if (fpu_valid_i) begin
                do op = 3'(rand_bits(3)); while (op > 3'd5 || !mask[op]);
                operator_i = fu_op_e'(op);
                rm_i       = 3'(rand_bits(3));
                if (op == FMIN_MAX) rm_i[1] = 1'b0;                   // Min or max only
                if (op == FCMP && rm_i[1:0] == 2'b11) rm_i[0] = 1'b0; // le, lt, eq only
                operand_a_i = pick_operand();
                operand_b_i = (rand_bits(2) == 0) ? operand_a_i : pick_operand();
                trans_id_i  = next_tag;
                next_tag++;
            end
        end
    endtask

    task automatic drain(input logic [5:0] mask);
        for (int t = 0; t < 100 && (exp_q.size() != 0 || fpu_valid_i); t++) step(0, 4, mask);
        if (exp_q.size() != 0 || fpu_valid_i) begin
            $display("Timeout: %0d results never came back", exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int n, input logic [5:0] mask,
                            input int rprob, input logic lat);
        int err0, iss0, stall0;
        err0      = errors;
        iss0      = issued;
        stall0    = stalls;
        lat_check = lat;
        for (int i = 0; i < n; i++) step(3, rprob, mask);
        drain(mask);
        if (rprob < 4 && stalls == stall0) begin
            $display("fpu_ready_o never dropped under back-pressure");
            errors++;
        end
        $display("test %-10s %0d ops, %0d errors", name, issued - iss0, errors - err0);
        tests++;
    endtask

    task automatic flush_test();
        int err0, iss0;
        err0      = errors;
        iss0      = issued;
        lat_check = 1'b0;
        for (int i = 0; i < 6; i++) step(4, 0, 6'b111111);   // Output stalled, everything fills
        flush_i        = 1'b1;
        fpu_valid_i    = 1'b0;
        result_ready_i = 1'b0;
        @(posedge clk_i);
        cycle++;
        exp_q.delete();                                      // These must never return
        #5;
        flush_i = 1'b0;
        for (int i = 0; i < 40; i++) step(3, 4, 6'b111111);
        drain(6'b111111);
        $display("test %-10s %0d ops, %0d errors", "flush", issued - iss0, errors - err0);
        tests++;
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        rst_i = 1'b1;
        flush_i = 1'b0;
        fpu_valid_i = 1'b0;
        result_ready_i = 1'b1;
        operator_i = FSGNJ;
        rm_i = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i = '0;
        next_tag = '0;
        {cycle, issued, stalls, errors, tests} = '0;
        timed_out = 1'b0;
        repeat (16) @(posedge clk_i);
        #5 rst_i = 1'b0;
        @(negedge clk_i);
        if (fpu_ready_o !== 1'b1 || result_valid_o !== 1'b0) begin
            $display("Handshake outputs are not idle after reset");
            errors++;
        end
        run_test("latency", 150, 6'b111111, 4, 1'b1);
        if (!timed_out) run_test("sgnj_fmv", 120, 6'b110001, 3, 1'b0);
        if (!timed_out) run_test("minmax", 150, 6'b000010, 3, 1'b0);
        if (!timed_out) run_test("cmp_class", 150, 6'b001100, 3, 1'b0);
        if (!timed_out) run_test("backpress", 300, 6'b111111, 2, 1'b0);
        if (!timed_out) flush_test();
        $display("Summary: %0d tests, %0d operations, %0d errors", tests, issued, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
src/fpu_wrap_pkg.sv
src/fpu_op_decoder.sv
src/fpu_hold_buffer.sv
src/fp32_noncomp_unit.sv
src/fpu_wrap_top.sv
sim/fpu_wrap_properties.sv
sim/fpu_wrap_tb.sv

// File: Bender.yml
package:
  name: fpu_wrap

sources:
  - src/fpu_wrap_pkg.sv
  - src/fpu_op_decoder.sv
  - src/fpu_hold_buffer.sv
  - src/fp32_noncomp_unit.sv
  - src/fpu_wrap_top.sv
  - target: simulation
    files:
      - sim/fpu_wrap_properties.sv
      - sim/fpu_wrap_tb.sv
